// File: verilog/usb_out_macros.svh
//////////////////////////////
// Sizing constants for the full-speed USB OUT protocol engine
// Include in any file that sizes endpoint vectors, put addresses or timers
//////////////////////////////

`ifndef USB_OUT_MACROS_SVH
`define USB_OUT_MACROS_SVH

// Implemented OUT endpoints and endpoint index width
`define USB_NUM_OUT_EPS 4
`define USB_OUT_EP_W $clog2(`USB_NUM_OUT_EPS)

// Largest packet the endpoint buffer takes, in bytes
`define USB_MAX_PKT_BYTES 32
`define USB_PUT_ADDR_W $clog2(`USB_MAX_PKT_BYTES)

// 17 bit times at 4 clocks per bit on the 48 MHz clock
`define USB_ACK_TIMEOUT_CNT 68
`define USB_TIMEOUT_W $clog2(`USB_ACK_TIMEOUT_CNT)

`endif

// File: verilog/usb_out_pkg.sv
//////////////////////////////
// Shared types for the USB OUT protocol engine
// PID codes, PID classes and the transaction FSM states
//////////////////////////////

package usb_out_pkg;

  // PID codes as seen in the low nibble of the PID byte
  typedef enum logic [3:0] {
    pid_out   = 4'b0001,
    pid_ack   = 4'b0010,
    pid_data0 = 4'b0011,
    pid_nak   = 4'b1010,
    pid_data1 = 4'b1011,
    pid_setup = 4'b1101,
    pid_stall = 4'b1110
  } usb_pid_e;

  // PID class lives in the two lowest PID bits
  typedef enum logic [1:0] {
    pid_type_special   = 2'b00,
    pid_type_token     = 2'b01,
    pid_type_handshake = 2'b10,
    pid_type_data      = 2'b11
  } usb_pid_type_e;

  // OUT / SETUP transaction progress
  typedef enum logic [2:0] {
    st_idle,
    st_rcvd_out,
    st_data_start,
    st_data_end
  } out_xact_state_e;

endpackage

// File: verilog/usb_rx_token_if.sv
//////////////////////////////
// Decoded receive events for the packet ending this cycle
// Driven by the token decoder, read by the FSM and the toggle register
//////////////////////////////

`timescale 1ns/1ps
`include "usb_out_macros.svh"

interface usb_rx_token_if;

  // Token strobes, already qualified by address and endpoint state
  logic out_hit;
  logic setup_hit;
  // Data phase strobes
  logic data_pkt;
  logic drop_pkt;
  logic bad_toggle;
  // Endpoint named in the packet
  logic ep_is_control;
  logic [`USB_OUT_EP_W-1:0] ep_idx;

  modport decoder (
    output out_hit, setup_hit, data_pkt, drop_pkt, bad_toggle, ep_is_control, ep_idx
  );
  modport fsm (
    input out_hit, setup_hit, data_pkt, drop_pkt, bad_toggle, ep_is_control, ep_idx
  );
  modport status (input setup_hit, ep_idx);

endinterface

// File: verilog/usb_rx_token_decode.sv
//////////////////////////////
// Classifies each finished receive packet
// Pure combinational, events valid in the rx_pkt_end_i cycle
//////////////////////////////

`timescale 1ns/1ps
`include "usb_out_macros.svh"

module usb_rx_token_decode (
  input  logic [6:0]                  dev_addr_i,
  input  logic                        rx_pkt_end_i,
  input  logic                        rx_pkt_valid_i,
  input  logic [3:0]                  rx_pid_i,
  input  logic [6:0]                  rx_addr_i,
  input  logic [3:0]                  rx_endp_i,
  input  logic [`USB_NUM_OUT_EPS-1:0] out_ep_enabled_i,
  input  logic [`USB_NUM_OUT_EPS-1:0] out_ep_control_i,
  input  logic [`USB_NUM_OUT_EPS-1:0] data_toggle_i,
  usb_rx_token_if.decoder             tok
);

  usb_out_pkg::usb_pid_e      pid;
  usb_out_pkg::usb_pid_type_e pid_type;
  logic                       ep_in_hw;
  logic                       ep_active;
  logic                       good_pkt;
  logic                       token_for_us;
  logic                       is_data;

  assign pid      = usb_out_pkg::usb_pid_e'(rx_pid_i);
  assign pid_type = usb_out_pkg::usb_pid_type_e'(rx_pid_i[1:0]);

  // Endpoints past the implemented range alias to index 0 but never go active
  assign ep_in_hw   = {1'b0, rx_endp_i} < 5'(`USB_NUM_OUT_EPS);
  assign tok.ep_idx = ep_in_hw ? rx_endp_i[`USB_OUT_EP_W-1:0] : '0;
  assign ep_active  = ep_in_hw && out_ep_enabled_i[tok.ep_idx];

  assign tok.ep_is_control = out_ep_control_i[tok.ep_idx];

  // Intact packet ending now
  assign good_pkt = rx_pkt_end_i && rx_pkt_valid_i;
  assign is_data  = (pid == usb_out_pkg::pid_data0) || (pid == usb_out_pkg::pid_data1);

  // Token class and our device address
  assign token_for_us = good_pkt && (pid_type == usb_out_pkg::pid_type_token) &&
                        (rx_addr_i == dev_addr_i);

  assign tok.out_hit   = token_for_us && ep_active && (pid == usb_out_pkg::pid_out);
  assign tok.setup_hit = token_for_us && ep_active && (pid == usb_out_pkg::pid_setup);

  assign tok.data_pkt = good_pkt && is_data;
  // CRC or bit-stuff errors, or anything that is not data
  assign tok.drop_pkt = rx_pkt_end_i && (!rx_pkt_valid_i || !is_data);

  // PID bit 3 separates DATA1 from DATA0
  assign tok.bad_toggle = tok.data_pkt && ep_active &&
                          (rx_pid_i[3] != data_toggle_i[tok.ep_idx]);

endmodule

// File: verilog/usb_out_xact_fsm.sv
//////////////////////////////
// OUT / SETUP transaction FSM
// Accepts tokens, waits for the data packet under a timeout
// and picks the handshake; handshake outputs are combinational
//////////////////////////////

`timescale 1ns/1ps
`include "usb_out_macros.svh"

module usb_out_xact_fsm (
  input  logic                          clk_48mhz_i,
  input  logic                          rst_ni,
  input  logic                          link_reset_i,
  usb_rx_token_if.fsm                   tok,
  input  logic                          rx_pkt_start_i,
  input  logic [`USB_NUM_OUT_EPS-1:0]   out_ep_full_i,
  input  logic [`USB_NUM_OUT_EPS-1:0]   out_ep_stall_i,
  input  logic                          nak_i,
  output usb_out_pkg::out_xact_state_e  state_o,
  output logic [3:0]                    ep_current_o,
  output logic                          newpkt_o,
  output logic                          acked_o,
  output logic                          rollback_o,
  output logic                          pkt_done_o,
  output logic                          tx_pkt_start_o,
  output logic [3:0]                    tx_pid_o
);

  localparam int unsigned TimeoutW = `USB_TIMEOUT_W;
  localparam logic [TimeoutW-1:0] TimeoutInit = TimeoutW'(`USB_ACK_TIMEOUT_CNT);

  usb_out_pkg::out_xact_state_e state_q, state_d;
  logic [TimeoutW-1:0]          timeout_q, timeout_d;
  logic                         xact_start;
  logic                         setup_q;
  logic [`USB_OUT_EP_W-1:0]     ep_idx;
  logic                         cant_take;

  assign state_o = state_q;
  assign ep_idx  = ep_current_o[`USB_OUT_EP_W-1:0];
  // Endpoint full now, or it filled up during the data phase
  assign cant_take = nak_i || out_ep_full_i[ep_idx];

  //////////////////////////////
  // Next state and handshake
  //////////////////////////////

  always_comb begin
    state_d        = state_q;
    timeout_d      = TimeoutInit;
    xact_start     = 1'b0;
    tx_pkt_start_o = 1'b0;
    tx_pid_o       = 4'b0000;
    acked_o        = 1'b0;
    rollback_o     = 1'b0;

    unique case (state_q)
      usb_out_pkg::st_idle: begin
        // SETUP only counts on a control endpoint
        if (tok.out_hit || (tok.setup_hit && tok.ep_is_control)) begin
          state_d    = usb_out_pkg::st_rcvd_out;
          xact_start = 1'b1;
        end
      end

      usb_out_pkg::st_rcvd_out: begin
        // Host must start its data packet before the counter runs out
        timeout_d = timeout_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = usb_out_pkg::st_data_start;
        end else if (timeout_q == '0) begin
          state_d = usb_out_pkg::st_idle;
        end
      end

      usb_out_pkg::st_data_start: begin
        if (tok.bad_toggle && !out_ep_stall_i[ep_idx]) begin
          // Repeat of a packet whose ACK got lost, ACK again and discard
          state_d        = usb_out_pkg::st_idle;
          rollback_o     = 1'b1;
          tx_pkt_start_o = 1'b1;
          tx_pid_o       = usb_out_pkg::pid_ack;
        end else if (tok.drop_pkt) begin
          // Corrupt or unexpected packet, stay silent
          state_d    = usb_out_pkg::st_idle;
          rollback_o = 1'b1;
        end else if (tok.data_pkt) begin
          state_d = usb_out_pkg::st_data_end;
        end
      end

      usb_out_pkg::st_data_end: begin
        state_d        = usb_out_pkg::st_idle;
        tx_pkt_start_o = 1'b1;
        if (setup_q) begin
          // SETUP is never NAKed, an unstorable one just vanishes
          if (cant_take) begin
            tx_pkt_start_o = 1'b0;
            rollback_o     = 1'b1;
          end else begin
            tx_pid_o = usb_out_pkg::pid_ack;
            acked_o  = 1'b1;
          end
        end else if (out_ep_stall_i[ep_idx]) begin
          tx_pid_o = usb_out_pkg::pid_stall;
        end else if (cant_take) begin
          tx_pid_o   = usb_out_pkg::pid_nak;
          rollback_o = 1'b1;
        end else begin
          tx_pid_o = usb_out_pkg::pid_ack;
          acked_o  = 1'b1;
        end
      end

      default: state_d = usb_out_pkg::st_idle;
    endcase
  end

  // Every ACKed data packet advances the endpoint toggle
  assign pkt_done_o = acked_o;

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= usb_out_pkg::st_idle;
      timeout_q <= TimeoutInit;
    end else begin
      state_q   <= link_reset_i ? usb_out_pkg::st_idle : state_d;
      timeout_q <= timeout_d;
    end
  end

  // Endpoint and transaction kind stay put until the next token
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      newpkt_o     <= 1'b0;
      ep_current_o <= '0;
      setup_q      <= 1'b0;
    end else begin
      newpkt_o <= xact_start;
      if (xact_start) begin
        ep_current_o <= 4'(tok.ep_idx);
        setup_q      <= tok.setup_hit;
      end
    end
  end

  state_legal_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    state_q inside {usb_out_pkg::st_idle, usb_out_pkg::st_rcvd_out,
                    usb_out_pkg::st_data_start, usb_out_pkg::st_data_end});

  tx_pid_handshake_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    tx_pkt_start_o |-> tx_pid_o inside {usb_out_pkg::pid_ack, usb_out_pkg::pid_nak,
                                        usb_out_pkg::pid_stall});

endmodule

// File: verilog/usb_out_data_path.sv
//////////////////////////////
// Receive byte path toward the endpoint buffer
// Registers bytes, forms put strobes and the put address
// and remembers a put that met a full endpoint
//////////////////////////////

`timescale 1ns/1ps
`include "usb_out_macros.svh"

module usb_out_data_path (
  input  logic                          clk_48mhz_i,
  input  logic                          rst_ni,
  input  usb_out_pkg::out_xact_state_e  state_i,
  input  logic [`USB_OUT_EP_W-1:0]      ep_current_i,
  input  logic [`USB_NUM_OUT_EPS-1:0]   out_ep_full_i,
  input  logic                          rx_data_put_i,
  input  logic [7:0]                    rx_data_i,
  output logic [7:0]                    out_ep_data_o,
  output logic                          out_ep_data_put_o,
  output logic [`USB_PUT_ADDR_W-1:0]    out_ep_put_addr_o,
  output logic                          nak_o
);

  localparam int unsigned AddrW = `USB_PUT_ADDR_W;
  localparam logic [AddrW-1:0] AddrMax = AddrW'(`USB_MAX_PKT_BYTES - 1);

  logic in_data;
  logic addr_inc;

  assign in_data = (state_i == usb_out_pkg::st_data_start);

  // Byte lines up with the put strobe one cycle later
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      out_ep_data_o <= rx_data_i;
    end
  end

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_data_put_o <= 1'b0;
    end else begin
      out_ep_data_put_o <= in_data && rx_data_put_i;
    end
  end

  // Any byte landing on a full endpoint dooms the whole packet
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_o <= 1'b0;
    end else if ((state_i == usb_out_pkg::st_idle) || (state_i == usb_out_pkg::st_rcvd_out)) begin
      nak_o <= 1'b0;
    end else if (out_ep_data_put_o && out_ep_full_i[ep_current_i]) begin
      nak_o <= 1'b1;
    end
  end

  // Hold still once NAKing and keep overlong packets on the last slot
  assign addr_inc = out_ep_data_put_o && !nak_o && (out_ep_put_addr_o != AddrMax);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_put_addr_o <= '0;
    end else if (state_i == usb_out_pkg::st_rcvd_out) begin
      out_ep_put_addr_o <= '0;
    end else if (addr_inc) begin
      out_ep_put_addr_o <= out_ep_put_addr_o + 1'b1;
    end
  end

  // A put never trails into the wait for the next data packet
  put_in_data_phase_a : assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    out_ep_data_put_o |-> state_i != usb_out_pkg::st_rcvd_out);

endmodule

// File: verilog/usb_out_toggle_reg.sv
//////////////////////////////
// Per-endpoint data toggles and SETUP flags
// SETUP restarts the toggle at DATA0, an ACKed packet flips it
//////////////////////////////

`timescale 1ns/1ps
`include "usb_out_macros.svh"

module usb_out_toggle_reg (
  input  logic                        clk_48mhz_i,
  input  logic                        rst_ni,
  input  logic                        link_reset_i,
  usb_rx_token_if.status              tok,
  input  logic                        pkt_done_i,
  input  logic [`USB_OUT_EP_W-1:0]    ep_current_i,
  input  logic                        out_ep_out_hit_i,
  output logic [`USB_NUM_OUT_EPS-1:0] data_toggle_o,
  output logic [`USB_NUM_OUT_EPS-1:0] out_ep_setup_o
);

  // Bus reset puts every endpoint back at DATA0
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_toggle_o <= '0;
    end else if (link_reset_i) begin
      data_toggle_o <= '0;
    end else if (tok.setup_hit) begin
      data_toggle_o[tok.ep_idx] <= 1'b0;
    end else if (pkt_done_i) begin
      data_toggle_o[ep_current_i] <= ~data_toggle_o[ep_current_i];
    end
  end

  // Flag marks a pending SETUP until the next OUT to that endpoint
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_setup_o <= '0;
    end else if (tok.setup_hit) begin
      out_ep_setup_o[tok.ep_idx] <= 1'b1;
    end else if (out_ep_out_hit_i) begin
      out_ep_setup_o[tok.ep_idx] <= 1'b0;
    end
  end

endmodule

// File: verilog/usb_fs_out_pe.sv
//////////////////////////////
// Full-speed USB OUT / SETUP protocol engine, non-buffered endpoints
// Sits between the packet receiver/transmitter and endpoint buffers
//////////////////////////////

`timescale 1ns/1ps
`include "usb_out_macros.svh"

module usb_fs_out_pe (
  input  logic                        clk_48mhz_i,
  input  logic                        rst_ni,
  input  logic                        link_reset_i,
  input  logic [6:0]                  dev_addr_i,
  // Endpoint side
  output logic [3:0]                  out_ep_current_o,
  output logic                        out_ep_data_put_o,
  output logic [`USB_PUT_ADDR_W-1:0]  out_ep_put_addr_o,
  output logic [7:0]                  out_ep_data_o,
  output logic                        out_ep_newpkt_o,
  output logic                        out_ep_acked_o,
  output logic                        out_ep_rollback_o,
  output logic [`USB_NUM_OUT_EPS-1:0] out_ep_setup_o,
  input  logic [`USB_NUM_OUT_EPS-1:0] out_ep_enabled_i,
  input  logic [`USB_NUM_OUT_EPS-1:0] out_ep_control_i,
  input  logic [`USB_NUM_OUT_EPS-1:0] out_ep_full_i,
  input  logic [`USB_NUM_OUT_EPS-1:0] out_ep_stall_i,
  output logic [`USB_NUM_OUT_EPS-1:0] out_data_toggle_o,
  // Receiver side
  input  logic                        rx_pkt_start_i,
  input  logic                        rx_pkt_end_i,
  input  logic                        rx_pkt_valid_i,
  input  logic [3:0]                  rx_pid_i,
  input  logic [6:0]                  rx_addr_i,
  input  logic [3:0]                  rx_endp_i,
  input  logic                        rx_data_put_i,
  input  logic [7:0]                  rx_data_i,
  // Transmitter side
  output logic                        tx_pkt_start_o,
  output logic [3:0]                  tx_pid_o
);

  usb_out_pkg::out_xact_state_e state;
  logic                         nak;
  logic                         pkt_done;

  usb_rx_token_if tok ();

  usb_rx_token_decode u_decode (
    .dev_addr_i       (dev_addr_i),
    .rx_pkt_end_i     (rx_pkt_end_i),
    .rx_pkt_valid_i   (rx_pkt_valid_i),
    .rx_pid_i         (rx_pid_i),
    .rx_addr_i        (rx_addr_i),
    .rx_endp_i        (rx_endp_i),
    .out_ep_enabled_i (out_ep_enabled_i),
    .out_ep_control_i (out_ep_control_i),
    .data_toggle_i    (out_data_toggle_o),
    .tok              (tok)
  );

  usb_out_xact_fsm u_fsm (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .link_reset_i   (link_reset_i),
    .tok            (tok),
    .rx_pkt_start_i (rx_pkt_start_i),
    .out_ep_full_i  (out_ep_full_i),
    .out_ep_stall_i (out_ep_stall_i),
    .nak_i          (nak),
    .state_o        (state),
    .ep_current_o   (out_ep_current_o),
    .newpkt_o       (out_ep_newpkt_o),
    .acked_o        (out_ep_acked_o),
    .rollback_o     (out_ep_rollback_o),
    .pkt_done_o     (pkt_done),
    .tx_pkt_start_o (tx_pkt_start_o),
    .tx_pid_o       (tx_pid_o)
  );

  usb_out_data_path u_data (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .state_i           (state),
    .ep_current_i      (out_ep_current_o[`USB_OUT_EP_W-1:0]),
    .out_ep_full_i     (out_ep_full_i),
    .rx_data_put_i     (rx_data_put_i),
    .rx_data_i         (rx_data_i),
    .out_ep_data_o     (out_ep_data_o),
    .out_ep_data_put_o (out_ep_data_put_o),
    .out_ep_put_addr_o (out_ep_put_addr_o),
    .nak_o             (nak)
  );

  usb_out_toggle_reg u_toggle (
    .clk_48mhz_i      (clk_48mhz_i),
    .rst_ni           (rst_ni),
    .link_reset_i     (link_reset_i),
    .tok              (tok),
    .pkt_done_i       (pkt_done),
    .ep_current_i     (out_ep_current_o[`USB_OUT_EP_W-1:0]),
    .out_ep_out_hit_i (tok.out_hit),
    .data_toggle_o    (out_data_toggle_o),
    .out_ep_setup_o   (out_ep_setup_o)
  );

endmodule

// File: tb/tb_usb_fs_out_pe.sv
//////////////////////////////
// Testbench for the USB OUT protocol engine
// Sends tokens and data packets, checks handshakes, puts,
// toggles and SETUP flags against a reference model
//////////////////////////////

`timescale 1ns/1ps
`include "usb_out_macros.svh"

module tb_usb_fs_out_pe;

  localparam int NumEps = `USB_NUM_OUT_EPS;
  localparam int AddrW = `USB_PUT_ADDR_W;
  localparam int AddrMax = `USB_MAX_PKT_BYTES - 1;
  localparam logic [6:0] DevAddr = 7'h2a;
  // About 15 transactions under 120 cycles each, one timeout wait, reset and margin
  localparam int MaxCycles = 4000;

  logic clk_48mhz_i, rst_ni, link_reset_i;
  logic [6:0] dev_addr_i, rx_addr_i;
  logic [3:0] out_ep_current_o, rx_pid_i, rx_endp_i, tx_pid_o;
  logic out_ep_data_put_o, out_ep_newpkt_o, out_ep_acked_o, out_ep_rollback_o;
  logic [AddrW-1:0] out_ep_put_addr_o;
  logic [7:0] out_ep_data_o, rx_data_i;
  logic [NumEps-1:0] out_ep_setup_o, out_ep_enabled_i, out_ep_control_i;
  logic [NumEps-1:0] out_ep_full_i, out_ep_stall_i, out_data_toggle_o;
  logic rx_pkt_start_i, rx_pkt_end_i, rx_pkt_valid_i, rx_data_put_i, tx_pkt_start_o;

  // Model state and expected events
  logic [NumEps-1:0] tog_model, setup_model;
  logic [3:0]        newpkt_q[$];
  logic [6:0]        hs_q[$];
  int                hs_cyc_q[$];
  logic [7+AddrW:0]  put_q[$];
  integer            seed;
  int                cycle, mismatches, failures;

  usb_fs_out_pe dut (.*);

  initial begin
    clk_48mhz_i = 1'b0;
    forever #20 clk_48mhz_i = ~clk_48mhz_i;
  end

  // Expected answer to a data packet as {send, pid, acked, rollback, new toggle}
  function automatic logic [7:0] expect_handshake(input logic setup, input logic stall,
      input logic full, input logic enabled, input logic tog_match, input logic old_tog);
    logic [3:0] pid;
    logic       send;
    logic       acked;
    logic       rollback;
    pid = 4'h0;
    send = 1'b0;
    acked = 1'b0;
    rollback = 1'b0;
    if (!enabled) begin
      send = 1'b0;
    end else if (!tog_match && !stall) begin
      // Retried packet gets an ACK but its data is thrown away
      send = 1'b1;
      pid = usb_out_pkg::pid_ack;
      rollback = 1'b1;
    end else if (setup) begin
      if (full) begin
        rollback = 1'b1;
      end else begin
        send = 1'b1;
        pid = usb_out_pkg::pid_ack;
        acked = 1'b1;
      end
    end else if (stall) begin
      send = 1'b1;
      pid = usb_out_pkg::pid_stall;
    end else if (full) begin
      send = 1'b1;
      pid = usb_out_pkg::pid_nak;
      rollback = 1'b1;
    end else begin
      send = 1'b1;
      pid = usb_out_pkg::pid_ack;
      acked = 1'b1;
    end
    return {send, pid, acked, rollback, old_tog ^ acked};
  endfunction

  task automatic send_token(input logic [3:0] pid, input logic [6:0] addr,
      input logic [3:0] endp);
    @(negedge clk_48mhz_i);
    rx_pkt_end_i = 1'b1;
    rx_pkt_valid_i = 1'b1;
    rx_pid_i = pid;
    rx_addr_i = addr;
    rx_endp_i = endp;
    @(negedge clk_48mhz_i);
    rx_pkt_end_i = 1'b0;
    rx_pkt_valid_i = 1'b0;
  endtask

  // Sends start, n random bytes and end and queues the expected puts and handshake
  task automatic send_data(input logic pid_bit, input int n, input logic accepted,
      input logic full, input logic [6:0] hs, input logic early);
    logic [7:0] data;
    int         addr;
    int         i;
    logic       nak;
    addr = 0;
    nak = 1'b0;
    @(negedge clk_48mhz_i);
    rx_pkt_start_i = 1'b1;
    @(negedge clk_48mhz_i);
    rx_pkt_start_i = 1'b0;
    for (i = 0; i < n; i++) begin
      @(negedge clk_48mhz_i);
      data = 8'($random(seed));
      rx_data_put_i = 1'b1;
      rx_data_i = data;
      if (accepted) begin
        put_q.push_back({data, AddrW'(addr)});
        // Address freezes once NAKing or at the last slot
        if (!nak && addr != AddrMax) addr++;
        if (full) nak = 1'b1;
      end
      @(negedge clk_48mhz_i);
      rx_data_put_i = 1'b0;
    end
    @(negedge clk_48mhz_i);
    rx_pkt_end_i = 1'b1;
    rx_pkt_valid_i = 1'b1;
    rx_pid_i = pid_bit ? usb_out_pkg::pid_data1 : usb_out_pkg::pid_data0;
    if (hs != 7'h0) begin
      hs_q.push_back(hs);
      hs_cyc_q.push_back(early ? cycle : cycle + 1);
    end
    @(negedge clk_48mhz_i);
    rx_pkt_end_i = 1'b0;
    rx_pkt_valid_i = 1'b0;
  endtask

  task automatic send_nothing(input int cycles);
    repeat (cycles) @(negedge clk_48mhz_i);
  endtask

  task automatic check_status();
    if (out_data_toggle_o !== tog_model) begin
      mismatches++;
      $display("Mismatch at %0t: toggles %b, expected %b", $time, out_data_toggle_o, tog_model);
    end
    if (out_ep_setup_o !== setup_model) begin
      mismatches++;
      $display("Mismatch at %0t: setup flags %b, expected %b", $time, out_ep_setup_o,
               setup_model);
    end
  endtask

  // Token plus data packet with the expectations from the model
  task automatic run_xact(input logic setup, input logic [6:0] addr, input int ep,
      input logic pid_bit, input int n);
    logic       enabled;
    logic       accepted;
    logic       tog;
    logic       full;
    logic       stall;
    logic [7:0] res;
    enabled = 1'b0;
    tog = 1'b0;
    full = 1'b0;
    stall = 1'b0;
    if (addr == DevAddr && ep < NumEps) begin
      enabled = out_ep_enabled_i[ep];
      tog = tog_model[ep];
      full = out_ep_full_i[ep];
      stall = out_ep_stall_i[ep];
    end
    accepted = enabled && (!setup || out_ep_control_i[ep]);
    // SETUP restarts at DATA0 and raises the flag while an OUT clears it
    if (enabled && setup) begin
      tog_model[ep] = 1'b0;
      setup_model[ep] = 1'b1;
      tog = 1'b0;
    end else if (enabled) begin
      setup_model[ep] = 1'b0;
    end
    if (accepted) newpkt_q.push_back(4'(ep));
    send_token(setup ? usb_out_pkg::pid_setup : usb_out_pkg::pid_out, addr, 4'(ep));
    res = expect_handshake(setup, stall, full, accepted, pid_bit == tog, tog);
    if (accepted) tog_model[ep] = res[0];
    send_data(pid_bit, n, accepted, full, res[7:1], accepted && (pid_bit != tog) && !stall);
    send_nothing(2);
    check_status();
  endtask

  //////////////////////////////
  // Output checker
  //////////////////////////////

  always @(posedge clk_48mhz_i) begin : compare_outputs
    logic [6:0]       hs;
    int               hs_cyc;
    logic [7+AddrW:0] put;
    logic [3:0]       ep;
    if (rst_ni && out_ep_newpkt_o) begin
      if (newpkt_q.size() == 0) begin
        failures++;
        $display("Unexpected newpkt pulse at %0t", $time);
      end else begin
        ep = newpkt_q.pop_front();
        if (out_ep_current_o !== ep) begin
          mismatches++;
          $display("Mismatch at %0t: current endpoint %0d, expected %0d", $time,
                   out_ep_current_o, ep);
        end
      end
    end
    if (rst_ni && out_ep_data_put_o) begin
      if (put_q.size() == 0) begin
        failures++;
        $display("Unexpected endpoint put at %0t", $time);
      end else begin
        put = put_q.pop_front();
        if ({out_ep_data_o, out_ep_put_addr_o} !== put) begin
          mismatches++;
          $display("Mismatch at %0t: put %h at %0d, expected %h at %0d", $time,
                   out_ep_data_o, out_ep_put_addr_o, put[7+AddrW:AddrW], put[AddrW-1:0]);
        end
      end
    end
    // Handshake, acked and rollback are checked together
    if (rst_ni && (tx_pkt_start_o || out_ep_acked_o || out_ep_rollback_o)) begin
      if (hs_q.size() == 0) begin
        failures++;
        $display("Unexpected handshake or status pulse at %0t, pid %h", $time, tx_pid_o);
      end else begin
        hs = hs_q.pop_front();
        hs_cyc = hs_cyc_q.pop_front();
        if (hs_cyc != cycle) begin
          mismatches++;
          $display("Mismatch at %0t: handshake in cycle %0d, expected %0d", $time, cycle, hs_cyc);
        end
        if ({tx_pkt_start_o, tx_pkt_start_o ? tx_pid_o : 4'h0, out_ep_acked_o,
             out_ep_rollback_o} !== hs) begin
          mismatches++;
          $display("Mismatch at %0t: start %b pid %h acked %b rollback %b, expected %b", $time,
                   tx_pkt_start_o, tx_pid_o, out_ep_acked_o, out_ep_rollback_o, hs);
        end
      end
    end
    cycle = cycle + 1;
  end

  initial begin
    repeat (MaxCycles) @(posedge clk_48mhz_i);
    $display("Timeout: run still busy after %0d cycles", MaxCycles);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    seed = 43;
    cycle = 0;
    mismatches = 0;
    failures = 0;
    tog_model = '0;
    setup_model = '0;
    rst_ni = 1'b0;
    link_reset_i = 1'b0;
    dev_addr_i = DevAddr;
    out_ep_enabled_i = 4'b0111;
    out_ep_control_i = 4'b0001;
    out_ep_full_i = '0;
    out_ep_stall_i = '0;
    rx_pkt_start_i = 1'b0;
    rx_pkt_end_i = 1'b0;
    rx_pkt_valid_i = 1'b0;
    rx_pid_i = 4'h0;
    rx_addr_i = 7'h0;
    rx_endp_i = 4'h0;
    rx_data_put_i = 1'b0;
    rx_data_i = 8'h0;
    send_nothing(10);
    rst_ni = 1'b1;
    send_nothing(2);
    check_status();

    // Good OUT followed by full and stalled endpoints
    run_xact(1'b0, DevAddr, 1, 1'b0, 8);
    out_ep_full_i = 4'b0100;
    run_xact(1'b0, DevAddr, 2, 1'b0, 4);
    out_ep_full_i = '0;
    out_ep_stall_i = 4'b0100;
    run_xact(1'b0, DevAddr, 2, 1'b0, 3);
    out_ep_stall_i = '0;
    // Retry with a stale toggle
    run_xact(1'b0, DevAddr, 1, ~tog_model[1], 5);
    // SETUP on control and non-control endpoints with an OUT after each
    run_xact(1'b1, DevAddr, 0, 1'b0, 8);
    run_xact(1'b0, DevAddr, 0, tog_model[0], 2);
    run_xact(1'b1, DevAddr, 1, 1'b0, 8);
    run_xact(1'b0, DevAddr, 1, tog_model[1], 3);
    // Wrong address, unimplemented and disabled endpoints
    run_xact(1'b0, DevAddr ^ 7'h01, 1, tog_model[1], 4);
    run_xact(1'b0, DevAddr, 5, 1'b0, 4);
    run_xact(1'b0, DevAddr, 3, 1'b0, 4);

    // Token with no data before the timeout and a late packet after it
    newpkt_q.push_back(4'd1);
    setup_model[1] = 1'b0;
    send_token(usb_out_pkg::pid_out, DevAddr, 4'd1);
    send_nothing(`USB_ACK_TIMEOUT_CNT + 8);
    send_data(tog_model[1], 4, 1'b0, 1'b0, 7'h0, 1'b0);
    send_nothing(2);
    check_status();

    // Overlong packet and a DATA1 toggle left on endpoint 2 before a link reset
    run_xact(1'b0, DevAddr, 1, tog_model[1], 40);
    run_xact(1'b0, DevAddr, 2, tog_model[2], 2);
    link_reset_i = 1'b1;
    send_nothing(1);
    link_reset_i = 1'b0;
    tog_model = '0;
    send_nothing(1);
    check_status();

    send_nothing(4);
    if (newpkt_q.size() != 0 || hs_q.size() != 0 || put_q.size() != 0) begin
      failures++;
      $display("Expected events never seen: %0d newpkt, %0d handshake, %0d put",
               newpkt_q.size(), hs_q.size(), put_q.size());
    end
    $display("Run finished: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/usb_out_pkg.sv
verilog/usb_rx_token_if.sv
verilog/usb_rx_token_decode.sv
verilog/usb_out_xact_fsm.sv
verilog/usb_out_data_path.sv
verilog/usb_out_toggle_reg.sv
verilog/usb_fs_out_pe.sv
tb/tb_usb_fs_out_pe.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_usb_fs_out_pe
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log

SIM     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) verilog/usb_out_macros.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
